//--- Bender.yml
package:
  name: vector_engine

sources:
  - hw/regex_pkg.sv
  - hw/thread_fifo.sv
  - hw/thread_arbiter.sv
  - hw/thread_executor.sv
  - hw/regex_lane.sv
  - hw/fetch_arbiter.sv
  - hw/vector_engine.sv
  - target: simulation
    files:
      - verif/vector_engine_assertions.sv
      - verif/tb_vector_engine.sv

//--- flist.f
hw/regex_pkg.sv
hw/thread_fifo.sv
hw/thread_arbiter.sv
hw/thread_executor.sv
hw/regex_lane.sv
hw/fetch_arbiter.sv
hw/vector_engine.sv
verif/vector_engine_assertions.sv
verif/tb_vector_engine.sv

//--- hw/fetch_arbiter.sv
`timescale 1ns/1ps

module fetch_arbiter (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [regex_pkg::num_lanes-1:0]            req_valid,
  input  regex_pkg::pc_t [regex_pkg::num_lanes-1:0]  req_addr,
  output logic [regex_pkg::num_lanes-1:0]            req_ready,
  output logic [regex_pkg::num_lanes-1:0]            rsp_valid,
  output regex_pkg::instr_t                          rsp_data,
  output logic                                       mem_req_valid,
  output regex_pkg::pc_t                             mem_req_addr,
  input  logic                                       mem_req_ready,
  input  logic                                       mem_rsp_valid,
  input  regex_pkg::instr_t                          mem_rsp_data
);
  import regex_pkg::*;

  logic outstanding_q;  // request sent, response not back yet
  logic owner_q;        // lane that gets the response
  logic last_q;         // lane granted last
  logic hold_q;         // request on the port but not taken
  logic hold_sel_q;
  logic rr_sel;
  logic sel;
  logic req_fire;

  // lane 1 wins when alone or when lane 0 had the previous turn
  assign rr_sel = req_valid[1] && (!req_valid[0] || !last_q);

  // a stalled request keeps its lane so the address stays put
  assign sel = hold_q ? hold_sel_q : rr_sel;

  assign mem_req_valid = !outstanding_q && (|req_valid);
  assign mem_req_addr  = req_addr[sel];
  assign req_fire      = mem_req_valid && mem_req_ready;
  assign rsp_data      = mem_rsp_data;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      req_ready[i] = mem_req_ready && !outstanding_q && (sel == i);
      rsp_valid[i] = mem_rsp_valid && outstanding_q && (owner_q == i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding_q <= 1'b0;
      owner_q       <= 1'b0;
      last_q        <= 1'b1;  // lane 0 first
      hold_q        <= 1'b0;
    end else begin
      hold_q <= mem_req_valid && !mem_req_ready;
      if (req_fire) begin
        outstanding_q <= 1'b1;
        owner_q       <= sel;
        last_q        <= sel;
      end else if (mem_rsp_valid) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    hold_sel_q <= sel;
  end

endmodule

//--- hw/regex_lane.sv
`timescale 1ns/1ps

module regex_lane #(
  parameter int lane = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ext_valid,
  input  regex_pkg::thread_t ext_thread,
  output logic               ext_ready,
  input  logic               loop_valid,
  input  regex_pkg::thread_t loop_thread,
  output logic               loop_ready,
  input  regex_pkg::char_t   window_char,
  input  logic               window_enable,
  input  logic               window_end,
  output logic               fetch_valid,
  output regex_pkg::pc_t     fetch_addr,
  input  logic               fetch_ready,
  input  logic               fetch_data_valid,
  input  regex_pkg::instr_t  fetch_data,
  output logic               out_valid,
  output regex_pkg::thread_t out_thread,
  input  logic               out_ready,
  output logic               accept,
  output logic               busy,
  output logic               full
);
  import regex_pkg::*;

  logic    q_wr_valid;
  thread_t q_wr_thread;
  logic    q_wr_ready;
  logic    q_rd_valid;
  thread_t q_rd_thread;
  logic    q_rd_ready;

  // lane 0 must never stall external input behind its own loop-back
  thread_arbiter #(
    .round_robin(lane != 0)
  ) i_arbiter (
    .clk       (clk),
    .rst       (rst),
    .a_valid   (ext_valid),
    .a_thread  (ext_thread),
    .a_ready   (ext_ready),
    .b_valid   (loop_valid),
    .b_thread  (loop_thread),
    .b_ready   (loop_ready),
    .out_valid (q_wr_valid),
    .out_thread(q_wr_thread),
    .out_ready (q_wr_ready)
  );

  thread_fifo i_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (q_wr_valid),
    .wr_thread(q_wr_thread),
    .wr_ready (q_wr_ready),
    .rd_valid (q_rd_valid),
    .rd_thread(q_rd_thread),
    .rd_ready (q_rd_ready)
  );

  thread_executor #(
    .lane(lane)
  ) i_executor (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (q_rd_valid),
    .in_thread       (q_rd_thread),
    .in_ready        (q_rd_ready),
    .window_char     (window_char),
    .window_enable   (window_enable),
    .window_end      (window_end),
    .fetch_valid     (fetch_valid),
    .fetch_addr      (fetch_addr),
    .fetch_ready     (fetch_ready),
    .fetch_data_valid(fetch_data_valid),
    .fetch_data      (fetch_data),
    .out_valid       (out_valid),
    .out_thread      (out_thread),
    .out_ready       (out_ready),
    .accept          (accept),
    .busy            (busy)
  );

  // a thread is knocking on a full queue that is not draining this cycle
  assign full = !q_wr_ready && q_wr_valid && !(q_rd_valid && q_rd_ready);

endmodule

//--- hw/regex_pkg.sv
package regex_pkg;

  // datapath widths
  localparam int pc_w       = 8;
  localparam int cc_id_w    = 1;  // two lanes
  localparam int char_w     = 8;
  localparam int instr_w    = 16;
  localparam int fifo_depth = 8;
  localparam int count_w    = 8;

  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int num_lanes  = 2;

  // opcode sits in the two msbs of the instruction
  localparam int opcode_lsb = instr_w - 2;

  typedef logic [pc_w-1:0]    pc_t;     // instruction address
  typedef logic [cc_id_w-1:0] cc_id_t;  // lane a thread belongs to
  typedef logic [char_w-1:0]  char_t;   // window character
  typedef logic [instr_w-1:0] instr_t;  // raw instruction word
  typedef logic [count_w-1:0] count_t;  // in-flight threads

  // MATCH carries the expected char in bits 7..0, SPLIT its jump target
  typedef enum logic [1:0] {
    MATCH  = 2'd0,
    SPLIT  = 2'd1,
    ACCEPT = 2'd2
  } opcode_e;

  // one thread on every valid/ready link, pc in the upper bits
  typedef struct packed {
    pc_t    pc;
    cc_id_t cc_id;
  } thread_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_DATA,
    EMIT_FIRST,
    EMIT_SECOND
  } exec_state_e;

endpackage

//--- hw/thread_arbiter.sv
`timescale 1ns/1ps

module thread_arbiter #(
  parameter bit round_robin = 1'b1
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               a_valid,
  input  regex_pkg::thread_t a_thread,
  output logic               a_ready,
  input  logic               b_valid,
  input  regex_pkg::thread_t b_thread,
  output logic               b_ready,
  output logic               out_valid,
  output regex_pkg::thread_t out_thread,
  input  logic               out_ready
);
  import regex_pkg::*;

  logic last_b_q;  // b took the last transfer
  logic prefer_b;
  logic grant_b;

  // fixed priority never favours b, so a sees the sink's ready directly
  assign prefer_b = round_robin && !last_b_q;

  // a is served unless b is waiting and has its turn
  assign grant_b = b_valid && (!a_valid || prefer_b);

  assign out_valid  = a_valid || b_valid;
  assign out_thread = grant_b ? b_thread : a_thread;

  // readies do not look at their own valid
  assign a_ready = out_ready && !(b_valid && prefer_b);
  assign b_ready = out_ready && (!a_valid || prefer_b);

  always_ff @(posedge clk) begin
    if (rst) begin
      last_b_q <= 1'b1;  // a goes first after reset
    end else if (out_valid && out_ready) begin
      last_b_q <= grant_b;
    end
  end

endmodule

//--- hw/thread_executor.sv
`timescale 1ns/1ps

module thread_executor #(
  parameter int lane = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  regex_pkg::thread_t in_thread,
  output logic               in_ready,
  input  regex_pkg::char_t   window_char,
  input  logic               window_enable,
  input  logic               window_end,
  output logic               fetch_valid,
  output regex_pkg::pc_t     fetch_addr,
  input  logic               fetch_ready,
  input  logic               fetch_data_valid,
  input  regex_pkg::instr_t  fetch_data,
  output logic               out_valid,
  output regex_pkg::thread_t out_thread,
  input  logic               out_ready,
  output logic               accept,
  output logic               busy
);
  import regex_pkg::*;

  exec_state_e state;
  exec_state_e state_next;
  thread_t     cur_q;   // thread under execution
  thread_t     out_q;   // successor presented on the output link
  pc_t         jump_q;  // split target, emitted second
  logic        split_q;
  opcode_e     opcode;
  char_t       expected;
  logic        rsp_taken;
  logic        matched;

  assign opcode    = opcode_e'(fetch_data[opcode_lsb +: 2]);
  assign expected  = fetch_data[char_w-1:0];
  assign rsp_taken = (state == WAIT_DATA) && fetch_data_valid;
  assign matched   = (opcode == MATCH) && (expected == window_char);

  assign in_ready    = (state == IDLE) && window_enable;  // pop only while the window is live
  assign fetch_valid = (state == FETCH);
  assign fetch_addr  = cur_q.pc;
  assign out_valid   = (state == EMIT_FIRST) || (state == EMIT_SECOND);
  assign out_thread  = out_q;
  assign busy        = (state != IDLE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (in_valid && in_ready) begin
          state_next = FETCH;
        end
      end
      FETCH: begin
        if (fetch_ready) begin
          state_next = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (fetch_data_valid) begin
          // mismatch, accept and unknown opcodes all end the thread here
          state_next = (matched || opcode == SPLIT) ? EMIT_FIRST : IDLE;
        end
      end
      EMIT_FIRST: begin
        if (out_ready) begin
          state_next = split_q ? EMIT_SECOND : IDLE;
        end
      end
      EMIT_SECOND: begin
        if (out_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      accept <= 1'b0;
    end else begin
      state  <= state_next;
      accept <= rsp_taken && (opcode == ACCEPT) && window_end;  // single cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      cur_q <= in_thread;
    end
    if (rsp_taken) begin
      split_q  <= (opcode == SPLIT);
      jump_q   <= fetch_data[pc_w-1:0];
      out_q.pc <= cur_q.pc + 1'b1;
      // a match moves on to the next lane, wrapping back to lane 0
      out_q.cc_id <= (opcode == SPLIT) ? cur_q.cc_id : cc_id_t'(lane + 1);
    end else if (state == EMIT_FIRST && out_ready) begin
      out_q.pc <= jump_q;  // second split branch, same cc_id
    end
  end

endmodule

//--- hw/thread_fifo.sv
`timescale 1ns/1ps

module thread_fifo (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_valid,
  input  regex_pkg::thread_t wr_thread,
  output logic               wr_ready,
  output logic               rd_valid,
  output regex_pkg::thread_t rd_thread,
  input  logic               rd_ready
);
  import regex_pkg::*;

  thread_t               mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;  // one extra bit to tell full from empty
  logic                  do_wr;
  logic                  do_rd;

  assign wr_ready  = (count != (fifo_ptr_w + 1)'(fifo_depth));
  assign rd_valid  = (count != '0);
  assign rd_thread = mem[rd_ptr];  // head of queue, visible the cycle after the write
  assign do_wr     = wr_valid && wr_ready;
  assign do_rd     = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_thread;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/vector_engine.sv
`timescale 1ns/1ps

module vector_engine (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       in_valid,
  input  regex_pkg::thread_t                         in_thread,
  output logic                                       in_ready,
  output logic                                       out_valid,
  output regex_pkg::thread_t                         out_thread,
  input  logic                                       out_ready,
  input  regex_pkg::char_t [regex_pkg::num_lanes-1:0] window_char,
  input  logic [regex_pkg::num_lanes-1:0]            window_enable,
  input  logic [regex_pkg::num_lanes-1:0]            window_end,
  output logic                                       mem_req_valid,
  output regex_pkg::pc_t                             mem_req_addr,
  input  logic                                       mem_req_ready,
  input  logic                                       mem_rsp_valid,
  input  regex_pkg::instr_t                          mem_rsp_data,
  output logic                                       accepts,
  output logic                                       running,
  output logic                                       full,
  output regex_pkg::count_t                          in_flight
);
  import regex_pkg::*;

  logic    [num_lanes-1:0] ext_valid;
  thread_t [num_lanes-1:0] ext_thread;
  logic    [num_lanes-1:0] ext_ready;
  logic    [num_lanes-1:0] loop_valid;
  logic    [num_lanes-1:0] loop_ready;
  logic    [num_lanes-1:0] lane_valid;
  thread_t [num_lanes-1:0] lane_thread;
  logic    [num_lanes-1:0] lane_ready;
  logic    [num_lanes-1:0] fetch_valid;
  pc_t     [num_lanes-1:0] fetch_addr;
  logic    [num_lanes-1:0] fetch_ready;
  logic    [num_lanes-1:0] fetch_rsp_valid;
  instr_t                  fetch_data;
  logic    [num_lanes-1:0] lane_accept;
  logic    [num_lanes-1:0] lane_busy;
  logic    [num_lanes-1:0] lane_full;
  logic                    in_fire;
  logic                    out_fire;

  // route each executor output by the lane its cc_id names
  always_comb begin
    ext_valid[0]  = in_valid;  // external threads, fixed priority in lane 0
    ext_thread[0] = in_thread;
    in_ready      = ext_ready[0];
    ext_valid[1]  = lane_valid[0] && (lane_thread[0].cc_id == cc_id_t'(1));
    ext_thread[1] = lane_thread[0];
    for (int i = 0; i < num_lanes; i++) begin
      loop_valid[i] = lane_valid[i] && (lane_thread[i].cc_id == cc_id_t'(i));
    end
    lane_ready[0] = (lane_thread[0].cc_id == cc_id_t'(0)) ? loop_ready[0] : ext_ready[1];
    // lane 1 threads wrapping to lane 0 belong to the next window
    out_valid     = lane_valid[1] && (lane_thread[1].cc_id == cc_id_t'(0));
    out_thread    = lane_thread[1];
    lane_ready[1] = (lane_thread[1].cc_id == cc_id_t'(1)) ? loop_ready[1] : out_ready;
  end

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    regex_lane #(
      .lane(i)
    ) i_lane (
      .clk             (clk),
      .rst             (rst),
      .ext_valid       (ext_valid[i]),
      .ext_thread      (ext_thread[i]),
      .ext_ready       (ext_ready[i]),
      .loop_valid      (loop_valid[i]),
      .loop_thread     (lane_thread[i]),
      .loop_ready      (loop_ready[i]),
      .window_char     (window_char[i]),
      .window_enable   (window_enable[i]),
      .window_end      (window_end[i]),
      .fetch_valid     (fetch_valid[i]),
      .fetch_addr      (fetch_addr[i]),
      .fetch_ready     (fetch_ready[i]),
      .fetch_data_valid(fetch_rsp_valid[i]),
      .fetch_data      (fetch_data),
      .out_valid       (lane_valid[i]),
      .out_thread      (lane_thread[i]),
      .out_ready       (lane_ready[i]),
      .accept          (lane_accept[i]),
      .busy            (lane_busy[i]),
      .full            (lane_full[i])
    );
  end

  fetch_arbiter i_fetch_arbiter (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (fetch_valid),
    .req_addr     (fetch_addr),
    .req_ready    (fetch_ready),
    .rsp_valid    (fetch_rsp_valid),
    .rsp_data     (fetch_data),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr (mem_req_addr),
    .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_data (mem_rsp_data)
  );

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else if (in_fire && !out_fire) begin
      in_flight <= in_flight + 1'b1;
    end else if (out_fire && !in_fire) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  assign accepts = |lane_accept;
  assign running = |lane_busy;  // some executor holds a thread
  assign full    = |lane_full;

endmodule

//--- verif/tb_vector_engine.sv
`timescale 1ns/1ps

module tb_vector_engine;
  import regex_pkg::*;

  localparam int timeout_cycles = 2000;
  localparam int stall_capacity = 2 * (fifo_depth + 1);  // both queues plus both executors

  logic               clk;
  logic               rst;
  logic               in_valid;
  thread_t            in_thread;
  logic               in_ready;
  logic               out_valid;
  thread_t            out_thread;
  logic               out_ready;
  char_t [1:0]        window_char;
  logic [1:0]         window_enable;
  logic [1:0]         window_end;
  logic               mem_req_valid;
  pc_t                mem_req_addr;
  logic               mem_req_ready;
  logic               mem_rsp_valid;
  instr_t             mem_rsp_data;
  logic               accepts;
  logic               running;
  logic               full;
  count_t             in_flight;

  instr_t prog [256];  // instruction memory contents
  int     rsp_wait;    // cycles until the pending response
  pc_t    rsp_addr;
  int     in_count;
  int     out_count;
  pc_t    out_pcs [32];
  int     cycles;
  int     sent;

  vector_engine i_vector_engine (.*);

  bind vector_engine vector_engine_assertions i_assertions (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_thread   (out_thread),
    .out_ready    (out_ready),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr (mem_req_addr),
    .mem_req_ready(mem_req_ready),
    .accepts      (accepts),
    .running      (running),
    .full         (full),
    .in_flight    (in_flight)
  );

  always #2 clk = ~clk;

  // memory model answers each accepted request 1 to 4 cycles later
  always @(posedge clk) begin
    mem_rsp_valid <= 1'b0;
    mem_req_ready <= ($urandom % 4) != 0;  // occasional stall
    if (rst) begin
      rsp_wait <= 0;
    end else if (rsp_wait != 0) begin
      if (rsp_wait == 1) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data  <= prog[rsp_addr];
      end
      rsp_wait <= rsp_wait - 1;
    end else if (mem_req_valid && mem_req_ready) begin
      rsp_addr <= mem_req_addr;
      rsp_wait <= 1 + ($urandom % 4);
    end
  end

  // transfer counters and output log
  always @(posedge clk) begin
    if (rst) begin
      in_count  <= 0;
      out_count <= 0;
    end else begin
      if (in_valid && in_ready) begin
        in_count <= in_count + 1;
      end
      if (out_valid && out_ready) begin
        out_pcs[out_count % 32] <= out_thread.pc;
        out_count <= out_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (i_vector_engine.i_assertions.error_count != 0) begin
      stop_with_failure("a protocol assertion on the DUT failed");
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected)
      else stop_with_failure($sformatf("[ERROR] %s: expected %0d, actual %0d",
                                       name, expected, actual));
  endtask

  task automatic tick(ref int count, input string what);
    @(posedge clk);
    count++;
    if (count > timeout_cycles) begin
      stop_with_failure($sformatf("timeout while waiting for %s", what));
    end
  endtask

  function automatic instr_t match_instr(input char_t c);
    return {2'd0, 6'd0, c};
  endfunction

  function automatic instr_t split_instr(input pc_t target);
    return {2'd1, 6'd0, target};
  endfunction

  function automatic instr_t accept_instr();
    return {2'd2, 14'd0};
  endfunction

  task automatic clear_program();
    for (int a = 0; a < 256; a++) begin
      prog[a] = {2'd2, 6'd0, pc_t'(a)};  // accept tagged with its own address
    end
  endtask

  task automatic apply_reset();
    rst       <= 1'b1;
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
  endtask

  task automatic send_thread(input pc_t pc);
    int waited;
    waited = 0;
    in_valid  <= 1'b1;
    in_thread <= '{pc: pc, cc_id: '0};
    @(posedge clk);
    while (!in_ready) begin
      tick(waited, "in_ready");
    end
    in_valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h6dd2));
    clk           = 1'b0;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_thread     = '0;
    out_ready     = 1'b1;
    window_char   = '0;
    window_enable = 2'b11;
    window_end    = 2'b00;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    clear_program();

    apply_reset();
    check_value("reset out_valid", 0, out_valid);
    check_value("reset mem_req_valid", 0, mem_req_valid);
    check_value("reset accepts", 0, accepts);
    check_value("reset running", 0, running);
    check_value("reset full", 0, full);
    check_value("reset in_flight", 0, in_flight);

    // pc 0 matches in lane 0 and pc 1 in lane 1, so pc 2 leaves for lane 0
    prog[0] = match_instr("a");
    prog[1] = match_instr("b");
    prog[2] = accept_instr();
    window_char <= {char_t'("b"), char_t'("a")};
    send_thread(8'd0);
    cycles = 0;
    while (out_count < 1) begin
      tick(cycles, "match chain output");
    end
    check_value("match chain pc", 2, out_pcs[0]);

    apply_reset();
    clear_program();
    prog[0] = match_instr("x");
    prog[1] = match_instr("a");  // a wrongly surviving thread would leave through lane 1
    window_char <= {char_t'("a"), char_t'("a")};
    send_thread(8'd0);
    cycles = 0;
    while (!running) begin
      tick(cycles, "mismatch thread start");
    end
    cycles = 0;
    while (running) begin
      tick(cycles, "mismatch thread end");
    end
    repeat (8) @(posedge clk);
    check_value("mismatch running", 0, running);
    check_value("mismatch outputs", 0, out_count);
    check_value("mismatch in_flight", 1, in_flight);

    // split 5 gives pc 1 and pc 5, each then matches once per lane
    apply_reset();
    clear_program();
    prog[0] = split_instr(8'd5);
    prog[1] = match_instr("a");
    prog[5] = match_instr("a");
    prog[2] = match_instr("a");
    prog[6] = match_instr("a");
    send_thread(8'd0);
    cycles = 0;
    while (out_count < 2) begin
      tick(cycles, "split outputs");
    end
    check_value("split low pc", 3, (out_pcs[0] < out_pcs[1]) ? out_pcs[0] : out_pcs[1]);
    check_value("split high pc", 7, (out_pcs[0] < out_pcs[1]) ? out_pcs[1] : out_pcs[0]);
    // one input leaving as two outputs takes the counter below zero
    check_value("split in_flight", count_t'(in_count - out_count), in_flight);

    apply_reset();
    clear_program();
    prog[0] = accept_instr();
    window_end <= 2'b01;
    send_thread(8'd0);
    cycles = 0;
    while (!accepts) begin
      tick(cycles, "accepts");
    end
    window_end <= 2'b00;

    // stalled output with random input bursts until every queue is full
    apply_reset();
    for (int a = 0; a < 256; a++) begin
      prog[a] = match_instr("a");
    end
    out_ready <= 1'b0;
    in_thread <= '{pc: 8'd0, cc_id: '0};
    sent   = 0;
    cycles = 0;
    while (sent < stall_capacity) begin
      tick(cycles, "lane 0 queue to fill");
      if (in_valid && in_ready) begin
        sent++;
      end
      if (sent < stall_capacity && (!in_valid || in_ready)) begin
        in_valid <= ($urandom % 3) != 0;  // a pending offer stays up until taken
      end
    end
    in_valid <= 1'b0;
    cycles = 0;
    while (!out_valid) begin
      tick(cycles, "stalled output");
    end
    cycles = 0;
    while (!full) begin
      tick(cycles, "lane 1 queue to report full");
    end
    repeat (6) @(posedge clk);
    check_value("stall in_ready", 0, in_ready);
    check_value("stall in_flight", in_count - out_count, in_flight);
    out_ready <= 1'b1;
    cycles = 0;
    while (out_count < in_count) begin
      tick(cycles, "drain of stalled threads");
    end
    @(posedge clk);
    check_value("drain in_flight", 0, in_flight);

    repeat (4) @(posedge clk);
    if (i_vector_engine.i_assertions.error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_with_failure("a protocol assertion on the DUT failed");
    end
  end

endmodule

//--- verif/vector_engine_assertions.sv
`timescale 1ns/1ps

module vector_engine_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid,
  input logic                  in_ready,
  input logic                  out_valid,
  input regex_pkg::thread_t    out_thread,
  input logic                  out_ready,
  input logic                  mem_req_valid,
  input regex_pkg::pc_t        mem_req_addr,
  input logic                  mem_req_ready,
  input logic                  accepts,
  input logic                  running,
  input logic                  full,
  input regex_pkg::count_t     in_flight
);
  import regex_pkg::*;

  int unsigned error_count = 0;  // polled from the testbench top
  logic        in_fire;
  logic        out_fire;

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  // one reset cycle leaves every control output low
  a_quiet_after_reset: assert property (@(posedge clk)
    rst |=> !out_valid && !mem_req_valid && !accepts && !running && !full
            && (in_flight == '0))
    else begin
      $error("control output high right after reset");
      error_count++;
    end

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_thread))
    else begin
      $error("output thread changed or dropped while stalled");
      error_count++;
    end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
    else begin
      $error("memory request changed or dropped while stalled");
      error_count++;
    end

  // only threads wrapping to lane 0 leave the engine
  a_out_lane: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_thread.cc_id == '0)
    else begin
      $error("output thread not tagged for lane 0");
      error_count++;
    end

  a_count_up: assert property (@(posedge clk) disable iff (rst)
    in_fire && !out_fire |=> in_flight == $past(in_flight) + 1'b1)
    else begin
      $error("in_flight did not count an input");
      error_count++;
    end

  a_count_down: assert property (@(posedge clk) disable iff (rst)
    out_fire && !in_fire |=> in_flight == $past(in_flight) - 1'b1)
    else begin
      $error("in_flight did not count an output");
      error_count++;
    end

  a_count_hold: assert property (@(posedge clk) disable iff (rst)
    in_fire == out_fire |=> $stable(in_flight))
    else begin
      $error("in_flight moved without a single transfer");
      error_count++;
    end

endmodule
